//--- verilog/lsu_obi_pkg.sv
package lsu_obi_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  // Byte address
  typedef logic [31:0] addr_t;
  // Bus data word
  typedef logic [31:0] data_t;
  // One enable per byte lane
  typedef logic [3:0]  be_t;
  // A channel check code
  typedef logic [8:0]  achk_t;
  // R channel check code
  typedef logic [4:0]  rchk_t;

  // Access size as seen by the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Per-transfer context, carried alongside the outstanding transfer
  typedef struct packed {
    logic [1:0] offset;
    lsu_size_e  size;
    logic       sext;
    logic       we;
  } trans_ctx_t;

  ////////////////////////////////////////
  // Integrity codes
  ////////////////////////////////////////

  // Bit 8: be/we group, bits 7:4 wdata bytes, bits 3:0 addr bytes
  // Byte groups carry odd parity, the be/we group even parity
  function automatic achk_t calc_achk(addr_t addr, data_t wdata, be_t be, logic we);
    achk_t code;
    code[8] = ^{be, we};
    for (int i = 0; i < 4; i++) begin
      code[4+i] = ~^wdata[8*i +: 8];
      code[i]   = ~^addr[8*i +: 8];
    end
    return code;
  endfunction

  // Bit 4: err with even parity, bits 3:0 rdata bytes with odd parity
  function automatic rchk_t calc_rchk(data_t rdata, logic err);
    rchk_t code;
    code[4] = ^err;
    for (int i = 0; i < 4; i++) begin
      code[i] = ~^rdata[8*i +: 8];
    end
    return code;
  endfunction

endpackage

//--- verilog/lsu_trans_if.sv
`timescale 1ns/10ps

// Transaction channel from control block to OBI adapter
interface lsu_trans_if import lsu_obi_pkg::*; ();
  logic       valid;
  logic       ready;
  addr_t      addr;
  logic       we;
  be_t        be;
  data_t      wdata;
  trans_ctx_t ctx;

  modport master (output valid, addr, we, be, wdata, ctx, input ready);
  modport slave (input valid, addr, we, be, wdata, ctx, output ready);
endinterface

// Response channel, consumer is always receptive so there is no ready
interface lsu_resp_if import lsu_obi_pkg::*; ();
  logic       valid;
  data_t      rdata;
  logic       err;
  logic       integrity_err;
  trans_ctx_t ctx;

  modport master (output valid, rdata, err, integrity_err, ctx);
  modport slave (input valid, rdata, err, integrity_err, ctx);
endinterface

//--- verilog/lsu_ctrl.sv
`timescale 1ns/10ps

module lsu_ctrl import lsu_obi_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,

  // Core request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  addr_t     req_addr_i,
  input  logic      req_we_i,
  input  lsu_size_e req_size_i,
  input  logic      req_signed_i,
  input  data_t     req_wdata_i,

  // Transaction channel towards the adapter
  lsu_trans_if.master trans
);

  be_t   be;
  data_t wdata;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Straight pass-through, no buffering here
  assign trans.valid = req_valid_i;
  assign req_ready_o = trans.ready;

  ////////////////////////////////////////
  // Byte enables and lane replication
  ////////////////////////////////////////

  always_comb begin
    case (req_size_i)
      SIZE_BYTE: begin
        be    = be_t'(4'b0001 << req_addr_i[1:0]);
        wdata = {4{req_wdata_i[7:0]}};
      end
      SIZE_HALF: begin
        be    = be_t'(4'b0011 << req_addr_i[1:0]);
        wdata = {2{req_wdata_i[15:0]}};
      end
      default: begin
        be    = 4'b1111;
        wdata = req_wdata_i;
      end
    endcase
  end

  assign trans.addr  = req_addr_i;
  assign trans.we    = req_we_i;
  assign trans.be    = be;
  assign trans.wdata = wdata;

  // Context needed later to align the load data
  assign trans.ctx.offset = req_addr_i[1:0];
  assign trans.ctx.size   = req_size_i;
  assign trans.ctx.sext   = req_signed_i;
  assign trans.ctx.we     = req_we_i;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Only naturally aligned accesses reach the bus
  property p_aligned;
    @(posedge clk_i) disable iff (!rst_n_i)
      (req_valid_i && req_ready_o) |->
        ((req_size_i == SIZE_WORD) ? (req_addr_i[1:0] == 2'b00) :
         (req_size_i == SIZE_HALF) ? !req_addr_i[0] : 1'b1);
  endproperty
  a_aligned: assert property (p_aligned);

  // Request held stable while waiting for ready
  property p_stable;
    @(posedge clk_i) disable iff (!rst_n_i)
      (trans.valid && !trans.ready) |=>
        (trans.valid && $stable({trans.addr, trans.we, trans.be, trans.wdata, trans.ctx}));
  endproperty
  a_stable: assert property (p_stable);

endmodule

//--- verilog/obi_integrity_fifo.sv
`timescale 1ns/10ps

module obi_integrity_fifo import lsu_obi_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Grant side
  input  logic       push_i,
  input  trans_ctx_t ctx_i,
  input  logic       gntpar_err_i,

  // Response side
  input  logic       pop_i,
  input  data_t      rdata_i,
  input  logic       err_i,
  input  rchk_t      rchk_i,

  output logic       full_o,
  output logic       empty_o,
  output trans_ctx_t ctx_o,

  output logic       gntpar_err_resp_o,
  output logic       rchk_err_resp_o,
  output logic       protocol_err_o
);

  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push_en;
  logic             pop_en;

  // Entry storage, one context and one gnt parity flag per slot
  trans_ctx_t ctx_mem [MAX_OUTSTANDING];
  logic       gnt_err_mem [MAX_OUTSTANDING];

  assign full_o  = (cnt_q == CNT_W'(MAX_OUTSTANDING));
  assign empty_o = (cnt_q == '0);

  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && !empty_o;

  ////////////////////////////////////////
  // Pointers and fill level
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Wrap at depth, which need not be a power of two
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      ctx_mem[wr_ptr_q]     <= ctx_i;
      gnt_err_mem[wr_ptr_q] <= gntpar_err_i;
    end
  end

  ////////////////////////////////////////
  // Response-timed checks
  ////////////////////////////////////////

  // Head entry seen in the rvalid cycle
  assign ctx_o             = ctx_mem[rd_ptr_q];
  assign gntpar_err_resp_o = pop_en && gnt_err_mem[rd_ptr_q];
  assign rchk_err_resp_o   = pop_en && (rchk_i != calc_rchk(rdata_i, err_i));
  // rvalid with no transfer outstanding
  assign protocol_err_o    = pop_i && empty_o;

  // Adapter must hold req low once full
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);

  a_ptr_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      (wr_ptr_q < MAX_OUTSTANDING) && (rd_ptr_q < MAX_OUTSTANDING));

endmodule

//--- verilog/obi_data_adapter.sv
`timescale 1ns/10ps

module obi_data_adapter import lsu_obi_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic   clk_i,
  input  logic   rst_n_i,

  // Transaction and response channels
  lsu_trans_if.slave trans,
  lsu_resp_if.master resp,

  // OBI A channel
  output logic   obi_req_o,
  output logic   obi_reqpar_o,
  input  logic   obi_gnt_i,
  input  logic   obi_gntpar_i,
  output addr_t  obi_addr_o,
  output logic   obi_we_o,
  output be_t    obi_be_o,
  output data_t  obi_wdata_o,
  output achk_t  obi_achk_o,

  // OBI R channel
  input  logic   obi_rvalid_i,
  input  logic   obi_rvalidpar_i,
  input  data_t  obi_rdata_i,
  input  logic   obi_err_i,
  input  rchk_t  obi_rchk_i,

  // Alarms
  output logic   integrity_err_o,
  output logic   protocol_err_o
);

  logic fifo_full;
  logic fifo_empty;
  logic gntpar_err;
  logic rvalidpar_err;
  logic gntpar_err_resp;
  logic rchk_err_resp;

  ////////////////////////////////////////
  // A channel
  ////////////////////////////////////////

  // No new request while every FIFO slot is taken
  assign obi_req_o    = trans.valid && !fifo_full;
  assign obi_reqpar_o = !obi_req_o;
  assign trans.ready  = obi_gnt_i && !fifo_full;

  assign obi_addr_o  = trans.addr;
  assign obi_we_o    = trans.we;
  assign obi_be_o    = trans.be;
  assign obi_wdata_o = trans.wdata;
  assign obi_achk_o  = calc_achk(trans.addr, trans.wdata, trans.be, trans.we);

  // Parity wires must always be the inverse of their signal
  assign gntpar_err    = (obi_gnt_i == obi_gntpar_i);
  assign rvalidpar_err = (obi_rvalid_i == obi_rvalidpar_i);

  obi_integrity_fifo #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_integrity_fifo (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .push_i            (obi_req_o && obi_gnt_i),
    .ctx_i             (trans.ctx),
    .gntpar_err_i      (gntpar_err),
    .pop_i             (obi_rvalid_i),
    .rdata_i           (obi_rdata_i),
    .err_i             (obi_err_i),
    .rchk_i            (obi_rchk_i),
    .full_o            (fifo_full),
    .empty_o           (fifo_empty),
    .ctx_o             (resp.ctx),
    .gntpar_err_resp_o (gntpar_err_resp),
    .rchk_err_resp_o   (rchk_err_resp),
    .protocol_err_o    (protocol_err_o)
  );

  ////////////////////////////////////////
  // R channel
  ////////////////////////////////////////

  // Spurious rvalid (nothing outstanding) is dropped here
  assign resp.valid         = obi_rvalid_i && !fifo_empty;
  assign resp.rdata         = obi_rdata_i;
  assign resp.err           = obi_err_i;
  assign resp.integrity_err = gntpar_err_resp || rvalidpar_err || rchk_err_resp;

  // Alarm fires at once, gnt error with grant timing
  assign integrity_err_o = gntpar_err || rvalidpar_err || rchk_err_resp;

endmodule

//--- verilog/lsu_load_align.sv
`timescale 1ns/10ps

module lsu_load_align import lsu_obi_pkg::*; (
  lsu_resp_if.slave resp,

  output logic  resp_valid_o,
  output logic  resp_err_o,
  output logic  resp_integrity_err_o,
  output data_t resp_rdata_o
);

  data_t shifted;

  // Move the addressed lane down to bit 0
  assign shifted = resp.rdata >> {resp.ctx.offset, 3'b000};

  always_comb begin
    case (resp.ctx.size)
      SIZE_BYTE: resp_rdata_o = {{24{resp.ctx.sext & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: resp_rdata_o = {{16{resp.ctx.sext & shifted[15]}}, shifted[15:0]};
      // Word, offset is always zero
      default:   resp_rdata_o = shifted;
    endcase
  end

  assign resp_valid_o         = resp.valid;
  assign resp_err_o           = resp.err;
  assign resp_integrity_err_o = resp.integrity_err;

endmodule

//--- verilog/lsu_obi_top.sv
`timescale 1ns/10ps

module lsu_obi_top import lsu_obi_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  logic      clk_i,
  input  logic      rst_n_i,

  // Core request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  addr_t     req_addr_i,
  input  logic      req_we_i,
  input  lsu_size_e req_size_i,
  input  logic      req_signed_i,
  input  data_t     req_wdata_i,

  // Core response
  output logic      resp_valid_o,
  output data_t     resp_rdata_o,
  output logic      resp_err_o,
  output logic      resp_integrity_err_o,

  // Alarms
  output logic      integrity_err_o,
  output logic      protocol_err_o,

  // OBI master
  output logic      obi_req_o,
  output logic      obi_reqpar_o,
  input  logic      obi_gnt_i,
  input  logic      obi_gntpar_i,
  output addr_t     obi_addr_o,
  output logic      obi_we_o,
  output be_t       obi_be_o,
  output data_t     obi_wdata_o,
  output achk_t     obi_achk_o,
  input  logic      obi_rvalid_i,
  input  logic      obi_rvalidpar_i,
  input  data_t     obi_rdata_i,
  input  logic      obi_err_i,
  input  rchk_t     obi_rchk_i
);

  lsu_trans_if u_trans_if ();
  lsu_resp_if  u_resp_if ();

  lsu_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_we_i     (req_we_i),
    .req_size_i   (req_size_i),
    .req_signed_i (req_signed_i),
    .req_wdata_i  (req_wdata_i),
    .trans        (u_trans_if.master)
  );

  obi_data_adapter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_adapter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trans           (u_trans_if.slave),
    .resp            (u_resp_if.master),
    .obi_req_o       (obi_req_o),
    .obi_reqpar_o    (obi_reqpar_o),
    .obi_gnt_i       (obi_gnt_i),
    .obi_gntpar_i    (obi_gntpar_i),
    .obi_addr_o      (obi_addr_o),
    .obi_we_o        (obi_we_o),
    .obi_be_o        (obi_be_o),
    .obi_wdata_o     (obi_wdata_o),
    .obi_achk_o      (obi_achk_o),
    .obi_rvalid_i    (obi_rvalid_i),
    .obi_rvalidpar_i (obi_rvalidpar_i),
    .obi_rdata_i     (obi_rdata_i),
    .obi_err_i       (obi_err_i),
    .obi_rchk_i      (obi_rchk_i),
    .integrity_err_o (integrity_err_o),
    .protocol_err_o  (protocol_err_o)
  );

  lsu_load_align u_load_align (
    .resp                 (u_resp_if.slave),
    .resp_valid_o         (resp_valid_o),
    .resp_err_o           (resp_err_o),
    .resp_integrity_err_o (resp_integrity_err_o),
    .resp_rdata_o         (resp_rdata_o)
  );

endmodule

//--- bench/obi_mem_slave.sv
`timescale 1ns/10ps

module obi_mem_slave import lsu_obi_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,

  // OBI A channel
  input  logic  obi_req_i,
  output logic  obi_gnt_o,
  output logic  obi_gntpar_o,
  input  addr_t obi_addr_i,
  input  logic  obi_we_i,
  input  be_t   obi_be_i,
  input  data_t obi_wdata_i,
  input  achk_t obi_achk_i,

  // OBI R channel
  output logic  obi_rvalid_o,
  output logic  obi_rvalidpar_o,
  output data_t obi_rdata_o,
  output logic  obi_err_o,
  output rchk_t obi_rchk_o,

  // Fault injection, one-cycle pulses
  input  logic  inj_gntpar_i,
  input  logic  inj_rvalidpar_i,
  input  logic  inj_rchk_i,
  input  logic  inj_spurious_i,

  // Sticky, set on any achk mismatch
  output logic  achk_err_o
);

  data_t       mem [256];
  data_t       rsp_data_q [$];
  logic        rsp_err_q [$];
  int unsigned rsp_due_q [$];
  int unsigned cyc;
  int unsigned last_due;
  logic        gntpar_fault_q;
  logic        rvalidpar_fault_q;
  logic        rchk_fault_q;
  logic        spurious_q;

  // Same fill as the shadow memory in the testbench
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), 8'(i) ^ 8'hA5, ~8'(i), 8'(i) + 8'h3C};
    end
  end

  // Bad gntpar only on a real grant, so exactly one transfer is hit
  assign obi_gntpar_o = (gntpar_fault_q && obi_req_i && obi_gnt_o) ? obi_gnt_o : !obi_gnt_o;

  always @(posedge clk_i or negedge rst_n_i) begin
    int unsigned idx;
    int unsigned due;
    logic        err;
    data_t       rd;
    if (!rst_n_i) begin
      obi_gnt_o         <= 1'b0;
      obi_rvalid_o      <= 1'b0;
      obi_rvalidpar_o   <= 1'b1;
      obi_rdata_o       <= '0;
      obi_err_o         <= 1'b0;
      obi_rchk_o        <= calc_rchk('0, 1'b0);
      achk_err_o        <= 1'b0;
      gntpar_fault_q    <= 1'b0;
      rvalidpar_fault_q <= 1'b0;
      rchk_fault_q      <= 1'b0;
      spurious_q        <= 1'b0;
      cyc      = 0;
      last_due = 0;
      rsp_data_q.delete();
      rsp_err_q.delete();
      rsp_due_q.delete();
    end else begin
      cyc = cyc + 1;
      // Latch requested faults until they are used
      if (inj_gntpar_i)    gntpar_fault_q    <= 1'b1;
      if (inj_rvalidpar_i) rvalidpar_fault_q <= 1'b1;
      if (inj_rchk_i)      rchk_fault_q      <= 1'b1;
      if (inj_spurious_i)  spurious_q        <= 1'b1;

      // Granted transfer, memory access happens here
      if (obi_req_i && obi_gnt_o) begin
        if (obi_achk_i != calc_achk(obi_addr_i, obi_wdata_i, obi_be_i, obi_we_i)) begin
          achk_err_o <= 1'b1;
        end
        idx = obi_addr_i[9:2];
        err = &obi_addr_i[9:8];
        rd  = err ? '0 : mem[idx];
        if (obi_we_i && !err) begin
          for (int b = 0; b < 4; b++) begin
            if (obi_be_i[b]) mem[idx][8*b +: 8] = obi_wdata_i[8*b +: 8];
          end
        end
        // Random latency, kept in order
        due = cyc + $urandom_range(3, 0);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_data_q.push_back(rd);
        rsp_err_q.push_back(err);
        rsp_due_q.push_back(due);
        if (gntpar_fault_q) gntpar_fault_q <= 1'b0;
      end

      // Grant about three cycles in four
      obi_gnt_o <= (($urandom % 4) != 0);

      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        rd  = rsp_data_q.pop_front();
        err = rsp_err_q.pop_front();
        due = rsp_due_q.pop_front();
        obi_rvalid_o      <= 1'b1;
        obi_rvalidpar_o   <= rvalidpar_fault_q;
        obi_rdata_o       <= rd;
        obi_err_o         <= err;
        obi_rchk_o        <= calc_rchk(rd, err) ^ rchk_t'(rchk_fault_q);
        rvalidpar_fault_q <= 1'b0;
        rchk_fault_q      <= 1'b0;
      end else if (spurious_q && rsp_due_q.size() == 0) begin
        // rvalid with nothing outstanding, otherwise well formed
        rd = $urandom;
        obi_rvalid_o    <= 1'b1;
        obi_rvalidpar_o <= 1'b0;
        obi_rdata_o     <= rd;
        obi_err_o       <= 1'b0;
        obi_rchk_o      <= calc_rchk(rd, 1'b0);
        spurious_q      <= 1'b0;
      end else begin
        obi_rvalid_o    <= 1'b0;
        obi_rvalidpar_o <= 1'b1;
      end
    end
  end

endmodule

//--- bench/tb_lsu_obi.sv
`timescale 1ns/10ps

module tb_lsu_obi import lsu_obi_pkg::*; ();

  localparam int unsigned TIMEOUT_CYCLES = 200;
  localparam int unsigned NUM_RANDOM     = 400;

  // One expected response, in request order
  typedef struct packed {
    logic  we;
    logic  err;
    logic  gnt_fault;
    logic  resp_fault;
    data_t rdata;
  } exp_t;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  logic      req_ready;
  addr_t     req_addr;
  logic      req_we;
  lsu_size_e req_size;
  logic      req_signed;
  data_t     req_wdata;
  logic      resp_valid;
  data_t     resp_rdata;
  logic      resp_err;
  logic      resp_integrity_err;
  logic      integrity_err;
  logic      protocol_err;
  logic      obi_req;
  logic      obi_reqpar;
  logic      obi_gnt;
  logic      obi_gntpar;
  addr_t     obi_addr;
  logic      obi_we;
  be_t       obi_be;
  data_t     obi_wdata;
  achk_t     obi_achk;
  logic      obi_rvalid;
  logic      obi_rvalidpar;
  data_t     obi_rdata;
  logic      obi_err;
  rchk_t     obi_rchk;
  logic      inj_gntpar;
  logic      inj_rvalidpar;
  logic      inj_rchk;
  logic      inj_spurious;
  logic      achk_err;

  data_t       shadow [256];
  exp_t        exp_q [$];
  logic        gnt_fault_pend;
  logic        resp_fault_pend;
  logic        spurious_pend;
  int unsigned n_accepted;
  int unsigned n_responses;
  int unsigned fail_count;
  int unsigned seed;

  always #10 clk = ~clk;

  lsu_obi_top #(
    .MAX_OUTSTANDING (2)
  ) u_dut (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .req_valid_i          (req_valid),
    .req_ready_o          (req_ready),
    .req_addr_i           (req_addr),
    .req_we_i             (req_we),
    .req_size_i           (req_size),
    .req_signed_i         (req_signed),
    .req_wdata_i          (req_wdata),
    .resp_valid_o         (resp_valid),
    .resp_rdata_o         (resp_rdata),
    .resp_err_o           (resp_err),
    .resp_integrity_err_o (resp_integrity_err),
    .integrity_err_o      (integrity_err),
    .protocol_err_o       (protocol_err),
    .obi_req_o            (obi_req),
    .obi_reqpar_o         (obi_reqpar),
    .obi_gnt_i            (obi_gnt),
    .obi_gntpar_i         (obi_gntpar),
    .obi_addr_o           (obi_addr),
    .obi_we_o             (obi_we),
    .obi_be_o             (obi_be),
    .obi_wdata_o          (obi_wdata),
    .obi_achk_o           (obi_achk),
    .obi_rvalid_i         (obi_rvalid),
    .obi_rvalidpar_i      (obi_rvalidpar),
    .obi_rdata_i          (obi_rdata),
    .obi_err_i            (obi_err),
    .obi_rchk_i           (obi_rchk)
  );

  obi_mem_slave u_slave (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .obi_req_i       (obi_req),
    .obi_gnt_o       (obi_gnt),
    .obi_gntpar_o    (obi_gntpar),
    .obi_addr_i      (obi_addr),
    .obi_we_i        (obi_we),
    .obi_be_i        (obi_be),
    .obi_wdata_i     (obi_wdata),
    .obi_achk_i      (obi_achk),
    .obi_rvalid_o    (obi_rvalid),
    .obi_rvalidpar_o (obi_rvalidpar),
    .obi_rdata_o     (obi_rdata),
    .obi_err_o       (obi_err),
    .obi_rchk_o      (obi_rchk),
    .inj_gntpar_i    (inj_gntpar),
    .inj_rvalidpar_i (inj_rvalidpar),
    .inj_rchk_i      (inj_rchk),
    .inj_spurious_i  (inj_spurious),
    .achk_err_o      (achk_err)
  );

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_count++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      abort_run("first mismatch reached");
    end
  endtask

  // Initial memory contents, a function of the word index
  function automatic data_t fill_word(int unsigned idx);
    logic [7:0] b;
    b = idx[7:0];
    return {b, b ^ 8'hA5, ~b, b + 8'h3C};
  endfunction

  // A channel code, each bit set so its group holds the required count of ones
  function automatic logic [8:0] expected_achk(input addr_t addr, input data_t wdata,
                                               input be_t be, input logic we);
    logic [8:0] code;
    int unsigned ones;
    for (int i = 0; i < 4; i++) begin
      // Address byte plus its bit hold an odd number of ones
      ones = $countones(addr[8*i +: 8]);
      code[i] = (ones % 2 == 0);
      // Same for the data byte
      ones = $countones(wdata[8*i +: 8]);
      code[4+i] = (ones % 2 == 0);
    end
    // be and we plus the bit hold an even number of ones
    ones = $countones({be, we});
    code[8] = (ones % 2 == 1);
    return code;
  endfunction

  // Reference model of one access: store into shadow, or expected load data
  task automatic model_access(input addr_t addr, input logic we, input lsu_size_e size,
                              input logic sgn, input data_t wdata, output exp_t e);
    int unsigned idx;
    int unsigned off;
    int unsigned nbytes;
    data_t       lane;
    idx    = addr[9:2];
    off    = addr[1:0];
    nbytes = 1 << size;
    e      = '0;
    e.we   = we;
    e.err  = (addr[9:8] == 2'b11);
    lane   = shadow[idx] >> (8 * off);
    // Store data bytes land at the addressed lanes, error region is not written
    if (we && !e.err) begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[idx][8*(off+b) +: 8] = wdata[8*b +: 8];
      end
    end
    case (size)
      SIZE_BYTE: e.rdata = sgn ? {{24{lane[7]}}, lane[7:0]} : {24'h0, lane[7:0]};
      SIZE_HALF: e.rdata = sgn ? {{16{lane[15]}}, lane[15:0]} : {16'h0, lane[15:0]};
      default:   e.rdata = lane;
    endcase
  endtask

  ////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////

  always @(posedge clk) begin
    exp_t head;
    exp_t entry;
    logic exp_int;
    if (rst_n) begin
      exp_int = 1'b0;
      check_value("obi_reqpar", !obi_req, obi_reqpar);
      check_value("slave achk", 1'b0, achk_err);
      if (obi_req) begin
        check_value("obi_achk", expected_achk(obi_addr, obi_wdata, obi_be, obi_we),
                    obi_achk);
      end
      // Only an armed spurious rvalid may pulse the protocol alarm
      if (protocol_err) begin
        check_value("protocol_err", 1'b1, spurious_pend);
        check_value("spurious resp_valid", 1'b0, resp_valid);
        spurious_pend <= 1'b0;
      end
      // rvalid with a transfer outstanding is a response in the same cycle
      check_value("resp_valid", obi_rvalid && (exp_q.size() != 0), resp_valid);
      if (resp_valid) begin
        head = exp_q.pop_front();
        n_responses++;
        check_value("resp_err", head.err, resp_err);
        check_value("resp_integrity_err", head.gnt_fault | head.resp_fault,
                    resp_integrity_err);
        if (!head.we && !head.err) check_value("resp_rdata", head.rdata, resp_rdata);
        exp_int = head.resp_fault;
      end
      // Accepted request becomes an expected response
      if (req_valid && req_ready) begin
        model_access(req_addr, req_we, req_size, req_signed, req_wdata, entry);
        entry.gnt_fault  = gnt_fault_pend;
        entry.resp_fault = resp_fault_pend;
        gnt_fault_pend  <= 1'b0;
        resp_fault_pend <= 1'b0;
        exp_int = exp_int | entry.gnt_fault;
        exp_q.push_back(entry);
        n_accepted++;
      end
      check_value("integrity_err", exp_int, integrity_err);
      check_value("outstanding within 2", 1'b1, exp_q.size() <= 2);
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Called on a rising edge, returns on the edge that accepted the request
  task automatic issue_req(input addr_t addr, input logic we, input lsu_size_e size,
                           input logic sgn, input data_t wdata);
    int unsigned waited;
    req_valid  <= 1'b1;
    req_addr   <= addr;
    req_we     <= we;
    req_size   <= size;
    req_signed <= sgn;
    req_wdata  <= wdata;
    waited = 0;
    @(posedge clk);
    while (!req_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) abort_run("request was never accepted");
      @(posedge clk);
    end
    req_valid <= 1'b0;
  endtask

  task automatic random_access();
    addr_t       addr;
    lsu_size_e   size;
    size = lsu_size_e'($urandom_range(2, 0));
    addr = $urandom;
    // Mostly a small window so loads hit earlier stores
    if (($urandom % 4) != 0) addr[9:6] = 4'b0000;
    case (size)
      SIZE_HALF: addr[0] = 1'b0;
      SIZE_WORD: addr[1:0] = 2'b00;
      default:   addr = addr;
    endcase
    issue_req(addr, 1'($urandom % 2), size, 1'($urandom % 2), $urandom);
  endtask

  // Queue is looked at mid-cycle, returns on a rising edge
  task automatic wait_idle();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) abort_run("outstanding responses never arrived");
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // kind 0 gntpar, 1 rvalidpar, 2 rchk
  task automatic arm_fault(input int unsigned kind);
    inj_gntpar    <= (kind == 0);
    inj_rvalidpar <= (kind == 1);
    inj_rchk      <= (kind == 2);
    if (kind == 0) gnt_fault_pend <= 1'b1;
    else resp_fault_pend <= 1'b1;
    @(posedge clk);
    inj_gntpar    <= 1'b0;
    inj_rvalidpar <= 1'b0;
    inj_rchk      <= 1'b0;
  endtask

  initial begin
    int unsigned waited;
    seed = $urandom(32'h540);
    clk  = 1'b0;
    rst_n           = 1'b0;
    req_valid       = 1'b0;
    req_addr        = '0;
    req_we          = 1'b0;
    req_size        = SIZE_WORD;
    req_signed      = 1'b0;
    req_wdata       = '0;
    inj_gntpar      = 1'b0;
    inj_rvalidpar   = 1'b0;
    inj_rchk        = 1'b0;
    inj_spurious    = 1'b0;
    gnt_fault_pend  = 1'b0;
    resp_fault_pend = 1'b0;
    spurious_pend   = 1'b0;
    n_accepted      = 0;
    n_responses     = 0;
    fail_count      = 0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(i);
    end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Sign and zero extension at every offset
    issue_req(32'h0000_000C, 1'b1, SIZE_WORD, 1'b0, 32'h80FF_7F01);
    for (int off = 0; off < 4; off++) begin
      issue_req(32'h0000_000C + off, 1'b0, SIZE_BYTE, 1'b1, '0);
      issue_req(32'h0000_000C + off, 1'b0, SIZE_BYTE, 1'b0, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_req(32'h0000_000C + off, 1'b0, SIZE_HALF, 1'b1, '0);
      issue_req(32'h0000_000C + off, 1'b0, SIZE_HALF, 1'b0, '0);
    end

    // Random traffic with random grant, latency and idle gaps
    for (int n = 0; n < NUM_RANDOM; n++) begin
      random_access();
      repeat ($urandom % 3) @(posedge clk);
    end
    // Error region load and store
    issue_req(32'h0000_0304, 1'b0, SIZE_WORD, 1'b0, '0);
    issue_req(32'h0000_03F8, 1'b1, SIZE_HALF, 1'b0, 32'h1234_5678);
    wait_idle();

    // One fault per transfer, each on an idle bus
    for (int kind = 0; kind < 3; kind++) begin
      arm_fault(kind);
      issue_req(32'h0000_0020 + 4 * kind, kind == 2, SIZE_WORD, 1'b0, 32'hCAFE_0000 + kind);
      wait_idle();
      issue_req(32'h0000_0020, 1'b0, SIZE_WORD, 1'b0, '0);
      wait_idle();
    end

    // Spurious rvalid with nothing outstanding
    inj_spurious  <= 1'b1;
    spurious_pend <= 1'b1;
    @(posedge clk);
    inj_spurious <= 1'b0;
    waited = 0;
    while (spurious_pend) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) abort_run("spurious rvalid raised no protocol error");
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    wait_idle();
    check_value("responses vs requests", n_accepted, n_responses);
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/lsu_obi_pkg.sv
verilog/lsu_trans_if.sv
verilog/lsu_ctrl.sv
verilog/obi_integrity_fifo.sv
verilog/obi_data_adapter.sv
verilog/lsu_load_align.sv
verilog/lsu_obi_top.sv
bench/obi_mem_slave.sv
bench/tb_lsu_obi.sv

//--- Bender.yml
package:
  name: lsu_obi

sources:
  - files:
      - verilog/lsu_obi_pkg.sv
      - verilog/lsu_trans_if.sv
      - verilog/lsu_ctrl.sv
      - verilog/obi_integrity_fifo.sv
      - verilog/obi_data_adapter.sv
      - verilog/lsu_load_align.sv
      - verilog/lsu_obi_top.sv
  - target: test
    files:
      - bench/obi_mem_slave.sv
      - bench/tb_lsu_obi.sv
